// File: rtl/fetch_cfg.svh
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// address and instruction widths
`define FETCH_PC_WIDTH        64
`define FETCH_INST_WIDTH      32

// pairs held toward decode, power of two and at least 2
`define FETCH_QUEUE_DEPTH     4
// memory requests allowed in flight
`define FETCH_MAX_OUTSTANDING 4
`define FETCH_RESET_PC        0

`endif

// File: rtl/fetch_pkg.sv
`include "fetch_cfg.svh"

package fetch_pkg;

	// taken branch target coming back from execute
	typedef struct packed {
		logic [`FETCH_PC_WIDTH-1:0] target;
	} redirect_t;

	// carried with each request and echoed by memory
	typedef struct packed {
		logic pc_low;                                   // bit 2 of the fetch pc
		logic epoch;                                    // path the request belongs to
	} fetch_tag_t;

	typedef struct packed {
		logic [`FETCH_PC_WIDTH-1:0] addr;               // 8 byte aligned block
		fetch_tag_t                 tag;
	} imem_req_t;

	typedef struct packed {
		logic [2*`FETCH_INST_WIDTH-1:0] data;           // two instructions, low one first
		logic [`FETCH_PC_WIDTH-1:0]     addr;           // echoed block address
		fetch_tag_t                     tag;            // echoed tag
	} imem_resp_t;

	// instruction pair handed to decode
	typedef struct packed {
		logic [`FETCH_PC_WIDTH-1:0]   addr;
		logic [`FETCH_INST_WIDTH-1:0] inst1;
		logic [`FETCH_INST_WIDTH-1:0] inst2;
		logic                         inst1_valid;
		logic                         inst2_valid;
	} fetch_pair_t;

endpackage

// File: rtl/fetch_pc_gen.sv
`timescale 1ns/100ps
`include "fetch_cfg.svh"

module fetch_pc_gen
(
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 redirect_valid,       // taken branch, always accepted
	input  fetch_pkg::redirect_t redirect,
	output logic                 imem_req_valid,
	input  logic                 imem_req_ready,
	output fetch_pkg::imem_req_t imem_req,
	input  logic                 resp_done,            // one response consumed by the filter
	output logic                 epoch
);
	import fetch_pkg::*;

	localparam int CNT_W = $clog2(`FETCH_MAX_OUTSTANDING + 1);
	localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(`FETCH_MAX_OUTSTANDING);

	logic [`FETCH_PC_WIDTH-1:0] pc;                    // next pc to request
	logic [`FETCH_PC_WIDTH-1:0] block_addr;
	logic [CNT_W-1:0]           outstanding;           // issued but not yet answered
	logic                       req_fire;
	logic                       slot_free;
	logic                       room;
	logic                       load;
	imem_req_t                  req_next;

	////////////////////
	// issue decision
	////////////////////

	assign block_addr = {pc[`FETCH_PC_WIDTH-1:3], 3'b000};
	assign req_fire   = imem_req_valid && imem_req_ready;
	assign slot_free  = !imem_req_valid || imem_req_ready;  // register empty or draining
	assign room       = (outstanding < CNT_MAX) || resp_done;
	// no new request on a redirect edge, the pc is still the old path
	assign load       = slot_free && room && !redirect_valid;

	always_comb
	begin
		req_next.addr       = block_addr;
		req_next.tag.pc_low = pc[2];                    // decides slot 1 validity later
		req_next.tag.epoch  = epoch;
	end

	////////////////////
	// pc and epoch
	////////////////////

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			pc    <= `FETCH_PC_WIDTH'(`FETCH_RESET_PC);
			epoch <= 1'b0;
		end
		else if (redirect_valid)
		begin
			pc    <= redirect.target;                   // keeps bit 2 of the target
			epoch <= ~epoch;                            // older responses go stale
		end
		else if (load)
			pc <= block_addr + `FETCH_PC_WIDTH'(8); // sequential, next aligned block
	end

	////////////////////
	// request register
	////////////////////

	always_ff @(posedge clock)
	begin
		if (reset)
			imem_req_valid <= 1'b0;
		else if (load)
			imem_req_valid <= 1'b1;
		else if (req_fire)
			imem_req_valid <= 1'b0;
	end

	// payload only moves when a new request is formed
	always_ff @(posedge clock)
	begin
		if (load)
			imem_req <= req_next;
	end

	// counts from issue into the register until the response is consumed
	always_ff @(posedge clock)
	begin
		if (reset)
			outstanding <= '0;
		else
			outstanding <= outstanding + CNT_W'(load) - CNT_W'(resp_done);
	end

endmodule

// File: rtl/fetch_resp_filter.sv
`timescale 1ns/100ps
`include "fetch_cfg.svh"

module fetch_resp_filter
(
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   redirect_valid,     // clears the register
	input  logic                   epoch,              // current path from the pc generator
	input  logic                   imem_resp_valid,
	output logic                   imem_resp_ready,
	input  fetch_pkg::imem_resp_t  imem_resp,
	output logic                   resp_done,
	output logic                   pair_valid,
	input  logic                   pair_ready,
	output fetch_pkg::fetch_pair_t pair
);
	import fetch_pkg::*;

	localparam int IW = `FETCH_INST_WIDTH;

	logic        resp_fire;
	logic        resp_live;                            // response belongs to the current path
	fetch_pair_t pair_next;

	// one entry, so ready only when empty or being drained
	assign imem_resp_ready = !pair_valid || pair_ready;
	assign resp_fire       = imem_resp_valid && imem_resp_ready;
	assign resp_done       = resp_fire;                 // stale ones free a slot too

	// a response on the redirect edge is still old path
	assign resp_live = resp_fire && !redirect_valid && (imem_resp.tag.epoch == epoch);

	always_comb
	begin
		pair_next.addr        = imem_resp.addr;
		pair_next.inst1       = imem_resp.data[IW-1:0];
		pair_next.inst2       = imem_resp.data[2*IW-1:IW];
		pair_next.inst1_valid = !imem_resp.tag.pc_low;  // high half target skips slot 1
		pair_next.inst2_valid = 1'b1;
	end

	////////////////////
	// pair register
	////////////////////

	always_ff @(posedge clock)
	begin
		if (reset)
			pair_valid <= 1'b0;
		else if (redirect_valid)
			pair_valid <= 1'b0;
		else if (resp_live)
			pair_valid <= 1'b1;                         // refill, even while draining
		else if (pair_ready)
			pair_valid <= 1'b0;
	end

	always_ff @(posedge clock)
	begin
		if (resp_live)
			pair <= pair_next;
	end

endmodule

// File: rtl/fetch_queue.sv
`timescale 1ns/100ps
`include "fetch_cfg.svh"

module fetch_queue
(
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   flush,              // redirect, drop everything held
	input  logic                   in_valid,
	output logic                   in_ready,
	input  fetch_pkg::fetch_pair_t in_pair,
	output logic                   out_valid,
	input  logic                   out_ready,
	output fetch_pkg::fetch_pair_t out_pair
);
	import fetch_pkg::*;

	localparam int DEPTH = `FETCH_QUEUE_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);
	localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(DEPTH);

	fetch_pair_t      entries [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;                           // pairs held
	logic             wr_en;
	logic             rd_en;

	assign in_ready  = (count != CNT_FULL);
	assign out_valid = (count != '0);
	assign out_pair  = entries[rd_ptr];                 // head is visible directly

	assign wr_en = in_valid && in_ready && !flush;      // old path pair, dropped
	assign rd_en = out_valid && out_ready;              // still delivered on a flush edge

	////////////////////
	// pointers and count
	////////////////////

	always_ff @(posedge clock)
	begin
		if (reset || flush)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (wr_en)
				wr_ptr <= wr_ptr + PTR_W'(1);       // power of two depth wraps by itself
			if (rd_en)
				rd_ptr <= rd_ptr + PTR_W'(1);
			count <= count + CNT_W'(wr_en) - CNT_W'(rd_en);
		end
	end

	// storage
	always_ff @(posedge clock)
	begin
		if (wr_en)
			entries[wr_ptr] <= in_pair;
	end

endmodule

// File: rtl/fetch_top.sv
`timescale 1ns/100ps

module fetch_top
(
	input  logic                   clock,
	input  logic                   reset,
	// taken branch from execute
	input  logic                   redirect_valid,
	input  fetch_pkg::redirect_t   redirect,
	// instruction memory
	output logic                   imem_req_valid,
	input  logic                   imem_req_ready,
	output fetch_pkg::imem_req_t   imem_req,
	input  logic                   imem_resp_valid,
	output logic                   imem_resp_ready,
	input  fetch_pkg::imem_resp_t  imem_resp,
	// toward decode
	output logic                   out_valid,
	input  logic                   out_ready,
	output fetch_pkg::fetch_pair_t out_pair
);
	import fetch_pkg::*;

	logic        epoch;                                // current path
	logic        resp_done;                            // frees an outstanding slot
	logic        pair_valid;
	logic        pair_ready;
	fetch_pair_t pair;                                 // filter to queue

	fetch_pc_gen pc_gen
	(
		.clock          (clock),
		.reset          (reset),
		.redirect_valid (redirect_valid),
		.redirect       (redirect),
		.imem_req_valid (imem_req_valid),
		.imem_req_ready (imem_req_ready),
		.imem_req       (imem_req),
		.resp_done      (resp_done),
		.epoch          (epoch)
	);

	fetch_resp_filter resp_filter
	(
		.clock           (clock),
		.reset           (reset),
		.redirect_valid  (redirect_valid),
		.epoch           (epoch),
		.imem_resp_valid (imem_resp_valid),
		.imem_resp_ready (imem_resp_ready),
		.imem_resp       (imem_resp),
		.resp_done       (resp_done),
		.pair_valid      (pair_valid),
		.pair_ready      (pair_ready),
		.pair            (pair)
	);

	fetch_queue queue
	(
		.clock     (clock),
		.reset     (reset),
		.flush     (redirect_valid),                    // wrong path pairs go away
		.in_valid  (pair_valid),
		.in_ready  (pair_ready),
		.in_pair   (pair),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_pair  (out_pair)
	);

endmodule

// File: verification/fetch_sva.sv
`timescale 1ns/100ps

module fetch_sva
(
	input logic                   clock,
	input logic                   reset,
	input logic                   redirect_valid,
	input logic                   imem_req_valid,
	input logic                   imem_req_ready,
	input fetch_pkg::imem_req_t   imem_req,
	input logic                   imem_resp_valid,
	input logic                   imem_resp_ready,
	input fetch_pkg::imem_resp_t  imem_resp,
	input logic                   out_valid,
	input logic                   out_ready,
	input fetch_pkg::fetch_pair_t out_pair
);

	// a waiting request keeps its payload, a redirect does not pull it back
	req_hold: assert property (@(posedge clock) disable iff (reset)
		imem_req_valid && !imem_req_ready |=> imem_req_valid && $stable(imem_req))
		else $error("memory request changed or dropped before it was accepted");

	resp_hold: assert property (@(posedge clock) disable iff (reset)
		imem_resp_valid && !imem_resp_ready |=> imem_resp_valid && $stable(imem_resp))
		else $error("memory response changed or dropped before it was accepted");

	// head of the queue only moves on a read or a flush
	out_hold: assert property (@(posedge clock) disable iff (reset)
		out_valid && !out_ready && !redirect_valid |=> out_valid && $stable(out_pair))
		else $error("output pair changed while decode was stalled");

endmodule

bind fetch_top fetch_sva sva (.*);

// File: verification/fetch_tb.sv
`timescale 1ns/100ps
`include "fetch_cfg.svh"

module fetch_tb;
	import fetch_pkg::*;

	localparam int PCW = `FETCH_PC_WIDTH;
	localparam int RESET_CYCLES = 16;
	localparam logic [PCW-1:0] RESET_PC = PCW'(`FETCH_RESET_PC);
	localparam logic [PCW-1:0] RESET_BLOCK = {RESET_PC[PCW-1:3], 3'b000};

	logic        clock;
	logic        reset;
	logic        redirect_valid;
	redirect_t   redirect;
	logic        imem_req_valid;
	logic        imem_req_ready;
	imem_req_t   imem_req;
	logic        imem_resp_valid;
	logic        imem_resp_ready;
	imem_resp_t  imem_resp;
	logic        out_valid;
	logic        out_ready;
	fetch_pair_t out_pair;

	integer         seed = 32'h3679;
	int             cycle = 0;                        // rising edges so far
	int             errors = 0;
	int             checks = 0;
	int             delivered = 0;                    // pairs taken by decode
	int             redirects = 0;
	bit             first_req_seen = 1'b0;
	bit             path_epoch = 1'b0;                // mirrors the fetch epoch bit
	logic [PCW-1:0] exp_addr = RESET_BLOCK;           // next pair decode should get
	logic           exp_inst1_valid = !RESET_PC[2];
	// requests taken by memory, oldest first, with the cycle their answer is due
	logic [PCW-1:0] mem_addr [$];
	fetch_tag_t     mem_tag [$];
	int             mem_due [$];

	fetch_top uut (.*);

	initial
	begin
		clock = 1'b0;
		forever #4 clock = ~clock;                    // 8 ns period
	end

	function automatic logic [31:0] inst_at(input logic [PCW-1:0] addr);
		return addr[31:0] ^ 32'hC0DE0000;             // memory content rule
	endfunction

	task automatic compare(input string name, input logic [63:0] actual,
		input logic [63:0] expected);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("Mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
		end
	endtask

	// one epoch bit only tells two paths apart, so the older path has to be gone
	function automatic bit old_path_drained();
		bit drained;
		drained = !(imem_req_valid && imem_req.tag.epoch != path_epoch);
		foreach (mem_tag[i])
			if (mem_tag[i].epoch != path_epoch)
				drained = 1'b0;
		return drained;
	endfunction

	////////////////////
	// one clock cycle
	////////////////////

	task automatic run_cycle(input bit allow_redirect);
		logic [31:0] hi;
		logic [31:0] lo;
		int          lat;
		@(posedge clock);
		cycle++;
		#1;
		reset           = (cycle < RESET_CYCLES);
		imem_req_ready  = ($random(seed) & 3) != 0;   // ready three cycles in four
		out_ready       = ($random(seed) & 1) != 0;   // decode stalls half the time
		imem_resp_valid = (mem_addr.size() != 0) && (mem_due[0] <= cycle);
		if (imem_resp_valid)
		begin
			imem_resp.addr = mem_addr[0];             // in order, oldest answers first
			imem_resp.tag  = mem_tag[0];
			imem_resp.data = {inst_at(mem_addr[0] + 64'd4), inst_at(mem_addr[0])};
		end
		redirect_valid = 1'b0;
		if (allow_redirect && ($unsigned($random(seed)) % 40) == 0 && old_path_drained())
		begin
			hi              = $random(seed);
			lo              = $random(seed);
			redirect_valid  = 1'b1;
			redirect.target = {hi, lo[31:2], 2'b00}; // word aligned, either half
		end
		#6;
		// everything settled, these handshakes fire on the coming edge
		if (cycle == RESET_CYCLES)
			compare("imem_req_valid", 64'(imem_req_valid), 64'd0);
		if (!first_req_seen)
			compare("out_valid", 64'(out_valid), 64'd0);
		if (imem_req_valid && imem_req_ready)
		begin
			if (!first_req_seen)
				compare("imem_req.addr", 64'(imem_req.addr), 64'(RESET_BLOCK));
			first_req_seen = 1'b1;
			lat = 1 + int'($unsigned($random(seed)) % 5);
			mem_addr.push_back(imem_req.addr);
			mem_tag.push_back(imem_req.tag);              // echoed untouched
			mem_due.push_back(cycle + 1 + lat);
		end
		if (imem_resp_valid && imem_resp_ready)
		begin
			mem_addr.delete(0);
			mem_tag.delete(0);
			mem_due.delete(0);
		end
		checks++;
		if (mem_addr.size() > `FETCH_MAX_OUTSTANDING)
		begin
			errors++;
			$display("ERROR at %0t: %0d requests in flight at memory, above the limit",
				$time, mem_addr.size());
		end
		if (out_valid && out_ready)
		begin
			// a pair taken on a redirect edge still belongs to the old path
			compare("out_pair.addr", 64'(out_pair.addr), 64'(exp_addr));
			compare("out_pair.inst1", 64'(out_pair.inst1), 64'(inst_at(exp_addr)));
			compare("out_pair.inst2", 64'(out_pair.inst2), 64'(inst_at(exp_addr + 64'd4)));
			compare("out_pair.inst1_valid", 64'(out_pair.inst1_valid), 64'(exp_inst1_valid));
			compare("out_pair.inst2_valid", 64'(out_pair.inst2_valid), 64'd1);
			exp_addr        = exp_addr + 64'd8;       // next aligned block
			exp_inst1_valid = 1'b1;
			delivered++;
		end
		if (redirect_valid)
		begin
			exp_addr        = {redirect.target[PCW-1:3], 3'b000};
			exp_inst1_valid = !redirect.target[2];    // high half target skips slot 1
			path_epoch      = !path_epoch;
			redirects++;
		end
	endtask

	////////////////////
	// main sequence
	////////////////////

	initial
	begin
		int wait_cycles;
		int target_count;
		reset           = 1'b1;
		redirect_valid  = 1'b0;
		redirect        = '0;
		imem_req_ready  = 1'b0;
		imem_resp_valid = 1'b0;
		imem_resp       = '0;
		out_ready       = 1'b0;
		repeat (RESET_CYCLES) run_cycle(1'b0);
		wait_cycles = 0;
		while (!first_req_seen && wait_cycles < 50)
		begin
			run_cycle(1'b0);
			wait_cycles++;
		end
		if (!first_req_seen)
		begin
			errors++;
			$display("ERROR: no memory request was accepted after reset");
		end
		else
		begin
			repeat (4000) run_cycle(1'b1);
			// redirects stop, decode has to keep receiving pairs
			target_count = delivered + 20;
			wait_cycles  = 0;
			while (delivered < target_count && wait_cycles < 1000)
			begin
				run_cycle(1'b0);
				wait_cycles++;
			end
			if (delivered < target_count)
			begin
				errors++;
				$display("ERROR: fetch stopped delivering pairs to decode");
			end
		end
		$display("%0d checks, %0d errors, %0d pairs delivered, %0d redirects",
			checks, errors, delivered, redirects);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

// File: compile.f
+incdir+rtl
rtl/fetch_pkg.sv
rtl/fetch_pc_gen.sv
rtl/fetch_resp_filter.sv
rtl/fetch_queue.sv
rtl/fetch_top.sv
verification/fetch_sva.sv
verification/fetch_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds the fetch testbench with Verilator, runs it and scans the log
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
	-f compile.f --top-module fetch_tb -Mdir obj_dir -o fetch_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/fetch_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Test FAILED" "$LOG"; then
	exit 1
fi
exit 0
